//--- verif/crc_tests.txt
// op (1 write, 0 read, f end) _ addr _ wdata _ expected prdata _ expected pslverr
0_08_00000000_00000000_0
0_0c_00000000_00000000_0
1_0c_a5c31e7f_00000000_0
0_0c_00000000_a5c31e7f_0
1_04_00000031_00000000_0
1_04_00000032_00000000_0
0_08_00000000_00000072_0
1_00_00000001_00000000_0
0_08_00000000_00000000_0
1_04_00000031_00000000_0
0_08_00000000_00000097_0
0_10_00000000_00000000_1
1_08_000000ff_00000000_1
1_1c_12345678_00000000_1
0_08_00000000_00000097_0
0_0c_00000000_a5c31e7f_0
f_00_00000000_00000000_0

//--- filelist.f
hdl/apb_crc_pkg.sv
hdl/design_ifs.sv
hdl/handshake_synchronizer.sv
hdl/apb_cdc.sv
hdl/crc_regs.sv
hdl/crc_engine.sv
hdl/apb_crc_top.sv
verif/apb_cdc_assertions.sv
verif/tb_apb_crc_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and check the log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_apb_crc_top -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi
# assertion errors keep running, the testbench counts them
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ] || grep -q "Test failed" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
exit 0

//--- verif/tb_apb_crc_top.sv
`timescale 1ns/1ps

module tb_apb_crc_top;

	logic        upstream_pclk = 1'b0;
	logic        downstream_pclk = 1'b0;
	logic        reset = 1'b1;
	logic        psel = 1'b0;
	logic        penable = 1'b0;
	logic        pwrite = 1'b0;
	logic [7:0]  paddr = 8'h00;
	logic [31:0] pwdata = 32'h0;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	// op, addr, wdata, expected prdata, expected pslverr
	logic [79:0] tests [0:31];
	integer      seed = 32'hcca45c20;
	int          errors = 0;
	int          n = 0;
	int          waited;

	always #50 downstream_pclk = ~downstream_pclk;
	// upstream clock unrelated to downstream
	always #35 upstream_pclk = ~upstream_pclk;

	apb_crc_top DUT (.*);

	initial begin
		$readmemh("verif/crc_tests.txt", tests);
		repeat (2) @(posedge upstream_pclk);
		#1 reset = 1'b0;
		// op f closes the list
		while (n < 32 && tests[n][79:76] != 4'hf) begin
			// random idle gap that also covers the downstream reset on the first pass
			repeat (3 + {$random(seed)} % 4) @(posedge upstream_pclk);
			// setup phase
			#1 psel = 1'b1;
			pwrite = tests[n][76];
			paddr  = tests[n][75:68];
			pwdata = tests[n][67:36];
			@(posedge upstream_pclk);
			#1 penable = 1'b1;
			waited = 0;
			// pready sampled just after the edge that sets it
			do begin
				@(posedge upstream_pclk);
				#1 waited++;
			end while (!pready && waited < 200);
			if (!pready) begin
				$display("error: no pready for address %h within 200 cycles", paddr);
				errors++;
				break;
			end
			if (prdata !== tests[n][35:4]) begin
				errors++;
				$display("mismatch at %0t: prdata expected %h, got %h",
					$time, tests[n][35:4], prdata);
			end
			if (pslverr !== tests[n][0]) begin
				errors++;
				$display("mismatch at %0t: pslverr expected %b, got %b",
					$time, tests[n][0], pslverr);
			end
			// transfer ends at this edge
			@(posedge upstream_pclk);
			#1 psel = 1'b0;
			penable = 1'b0;
			n++;
		end
		errors += DUT.u_cdc.cdc_checks.up_fails;
		errors += DUT.u_cdc.cdc_checks.down_fails;
		$display("%0d accesses, %0d errors", n, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- verif/apb_cdc_assertions.sv
`timescale 1ns/1ps

// apb protocol checks on both sides of the crossing
module apb_cdc_assertions (
	input logic upstream_pclk,
	input logic downstream_pclk,
	input logic reset,
	input logic pready,
	input logic ds_psel,
	input logic ds_penable,
	input logic ds_pready
);

	// failure counts per clock domain
	int up_fails = 0;
	int down_fails = 0;

	// upstream pready is a one cycle pulse
	assert property (@(posedge upstream_pclk) disable iff (reset) pready |=> !pready)
		else begin
			up_fails++;
			$error("upstream pready high for more than one cycle");
		end
	// penable only with psel, and after a setup cycle
	assert property (@(posedge downstream_pclk) disable iff (reset)
		ds_penable |-> ds_psel && $past(ds_psel))
		else begin
			down_fails++;
			$error("downstream penable without a preceding psel");
		end
	// psel held until the completer answers
	assert property (@(posedge downstream_pclk) disable iff (reset)
		ds_psel && !(ds_penable && ds_pready) |=> ds_psel)
		else begin
			down_fails++;
			$error("downstream psel dropped before pready");
		end

endmodule

bind apb_cdc apb_cdc_assertions cdc_checks (
	.upstream_pclk   (upstream_pclk),
	.downstream_pclk (downstream_pclk),
	.reset           (reset),
	.pready          (pready),
	.ds_psel         (downstream.psel),
	.ds_penable      (downstream.penable),
	.ds_pready       (downstream.pready)
);

//--- hdl/apb_crc_top.sv
`timescale 1ns/1ps

module apb_crc_top #(
	parameter logic [7:0] CRC_POLY = 8'h07
) (
	input  logic                            upstream_pclk,
	input  logic                            downstream_pclk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [apb_crc_pkg::ADDR_W-1:0]  paddr,
	input  logic [apb_crc_pkg::DATA_W-1:0]  pwdata,
	output logic [apb_crc_pkg::DATA_W-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr
);

	// downstream apb and crc steering
	apb_if dbus ();
	crc_if crc_bus ();

	// upstream apb into downstream domain
	apb_cdc u_cdc (
		.upstream_pclk   (upstream_pclk),
		.reset           (reset),
		.downstream_pclk (downstream_pclk),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.downstream      (dbus.requester)
	);

	// register block
	crc_regs u_regs (
		.downstream_pclk (downstream_pclk),
		.reset           (reset),
		.bus             (dbus.completer),
		.crc             (crc_bus.steer)
	);

	// crc accumulator
	crc_engine #(.CRC_POLY(CRC_POLY)) u_engine (
		.downstream_pclk (downstream_pclk),
		.reset           (reset),
		.crc             (crc_bus.engine)
	);

endmodule

//--- hdl/crc_engine.sv
`timescale 1ns/1ps

module crc_engine #(
	parameter logic [7:0] CRC_POLY = 8'h07
) (
	input  logic  downstream_pclk,
	input  logic  reset,
	crc_if.engine crc
);

	// one byte through the crc, msb first, no reflection
	function automatic logic [7:0] fold_byte(input logic [7:0] cur, input logic [7:0] data);
		logic [7:0] r;
		r = cur ^ data;
		for (int i = 0; i < 8; i++) begin
			// shift out the top bit, xor poly if it was set
			if (r[7])
				r = {r[6:0], 1'b0} ^ CRC_POLY;
			else
				r = {r[6:0], 1'b0};
		end
		return r;
	endfunction

	// crc updates the cycle after the pulse
	always_ff @(posedge downstream_pclk) begin
		if (reset || crc.clear)
			crc.crc <= apb_crc_pkg::CRC_INIT;
		else if (crc.byte_valid)
			crc.crc <= fold_byte(crc.crc, crc.data_byte);
	end

	// no final xor, result read as is

endmodule

//--- hdl/crc_regs.sv
`timescale 1ns/1ps

module crc_regs (
	input  logic       downstream_pclk,
	input  logic       reset,
	apb_if.completer   bus,
	crc_if.steer       crc
);

	apb_crc_pkg::crc_reg_e reg_sel;

	logic                           access;
	logic                           wr;
	logic                           err;
	logic [apb_crc_pkg::DATA_W-1:0] rdata;
	logic [apb_crc_pkg::DATA_W-1:0] scratch;

	// offsets outside the enum fall to the default branch
	assign reg_sel = apb_crc_pkg::crc_reg_e'(bus.paddr);

	assign access = bus.psel && bus.penable;
	assign wr     = access && bus.pwrite;

	// decode
	always_comb begin
		err   = 1'b0;
		rdata = '0;
		case (reg_sel)
			apb_crc_pkg::CRC_CTRL:    rdata = '0;
			apb_crc_pkg::CRC_DATA:    rdata = '0;
			// read only
			apb_crc_pkg::CRC_RESULT:  begin
				rdata = {{(apb_crc_pkg::DATA_W-8){1'b0}}, crc.crc};
				err   = bus.pwrite;
			end
			apb_crc_pkg::CRC_SCRATCH: rdata = scratch;
			default:                  err   = 1'b1;
		endcase
	end

	// zero wait states
	assign bus.pready  = access;
	assign bus.pslverr = access && err;
	// errored or write accesses return zero
	assign bus.prdata  = (access && !bus.pwrite && !err) ? rdata : '0;

	// one cycle pulses, access phase lasts a single cycle
	assign crc.clear      = wr && (reg_sel == apb_crc_pkg::CRC_CTRL) && bus.pwdata[0];
	assign crc.byte_valid = wr && (reg_sel == apb_crc_pkg::CRC_DATA);
	assign crc.data_byte  = bus.pwdata[7:0];

	// scratch register
	always_ff @(posedge downstream_pclk) begin
		if (reset)
			scratch <= '0;
		else if (wr && (reg_sel == apb_crc_pkg::CRC_SCRATCH))
			scratch <= bus.pwdata;
	end

endmodule

//--- hdl/apb_cdc.sv
`timescale 1ns/1ps

module apb_cdc (
	input  logic                            upstream_pclk,
	input  logic                            reset,
	input  logic                            downstream_pclk,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [apb_crc_pkg::ADDR_W-1:0]  paddr,
	input  logic [apb_crc_pkg::DATA_W-1:0]  pwdata,
	output logic [apb_crc_pkg::DATA_W-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	apb_if.requester                        downstream
);

	// reset synchronizer, downstream domain
	logic reset_meta;
	logic reset_down;

	// request level seen downstream, plus its delayed copy
	logic req_b;
	logic req_b_q;
	logic req_rise;
	// downstream access finished
	logic done_b;

	always_ff @(posedge downstream_pclk) begin
		reset_meta <= reset;
		reset_down <= reset_meta;
	end

	// upstream access phase starts a crossing, fsm ignores it unless idle
	handshake_synchronizer u_handshake (
		.clk_a      (upstream_pclk),
		.reset_a    (reset),
		.start      (psel && penable),
		.finished_a (pready),
		.clk_b      (downstream_pclk),
		.reset_b    (reset_down),
		.done_b     (done_b),
		.req_b      (req_b)
	);

	assign req_rise = req_b && !req_b_q;

	// downstream setup and access phases
	always_ff @(posedge downstream_pclk) begin
		if (reset_down) begin
			req_b_q            <= 1'b0;
			done_b             <= 1'b0;
			downstream.psel    <= 1'b0;
			downstream.penable <= 1'b0;
		end else begin
			req_b_q <= req_b;
			done_b  <= 1'b0;
			if (req_rise) begin
				// setup phase
				downstream.psel <= 1'b1;
			end else if (downstream.psel && !downstream.penable) begin
				// access phase next cycle
				downstream.penable <= 1'b1;
			end else if (downstream.penable && downstream.pready) begin
				// completer done, end access and tell upstream
				downstream.psel    <= 1'b0;
				downstream.penable <= 1'b0;
				done_b             <= 1'b1;
			end
		end
	end

	// upstream request fields are held stable while req is up
	always_ff @(posedge downstream_pclk) begin
		if (req_rise) begin
			downstream.paddr  <= paddr;
			downstream.pwrite <= pwrite;
			downstream.pwdata <= pwdata;
		end
		// response captured a cycle before ack rises
		if (downstream.penable && downstream.pready) begin
			prdata  <= downstream.prdata;
			pslverr <= downstream.pslverr;
		end
	end

endmodule

//--- hdl/handshake_synchronizer.sv
`timescale 1ns/1ps

module handshake_synchronizer (
	input  logic clk_a,
	input  logic reset_a,
	input  logic start,
	output logic finished_a,
	input  logic clk_b,
	input  logic reset_b,
	input  logic done_b,
	output logic req_b
);

	apb_crc_pkg::hs_state_e state;

	// request level, a domain
	logic       req_a;
	// req into b, ack into a
	logic [1:0] req_sync;
	logic [1:0] ack_sync;
	// acknowledge level, b domain
	logic       ack_b;

	// a side fsm
	always_ff @(posedge clk_a) begin
		if (reset_a) begin
			state      <= apb_crc_pkg::HS_IDLE;
			req_a      <= 1'b0;
			finished_a <= 1'b0;
			ack_sync   <= 2'b00;
		end else begin
			ack_sync   <= {ack_sync[0], ack_b};
			finished_a <= 1'b0;
			case (state)
				apb_crc_pkg::HS_IDLE: begin
					if (start) begin
						req_a <= 1'b1;
						state <= apb_crc_pkg::HS_REQ;
					end
				end
				apb_crc_pkg::HS_REQ: begin
					// ack seen, one cycle done pulse and drop req
					if (ack_sync[1]) begin
						req_a      <= 1'b0;
						finished_a <= 1'b1;
						state      <= apb_crc_pkg::HS_WAIT_ACK_LOW;
					end
				end
				apb_crc_pkg::HS_WAIT_ACK_LOW: begin
					// no new request until ack has fallen
					if (!ack_sync[1])
						state <= apb_crc_pkg::HS_IDLE;
				end
				default: state <= apb_crc_pkg::HS_IDLE;
			endcase
		end
	end

	// b side, ack set by done and held until req falls
	always_ff @(posedge clk_b) begin
		if (reset_b) begin
			req_sync <= 2'b00;
			ack_b    <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], req_a};
			if (done_b)
				ack_b <= 1'b1;
			else if (!req_b)
				ack_b <= 1'b0;
		end
	end

	assign req_b = req_sync[1];

endmodule

//--- hdl/design_ifs.sv
`timescale 1ns/1ps

// apb3 style bus between the crossing and the completer
interface apb_if;

	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [apb_crc_pkg::ADDR_W-1:0]  paddr;
	logic [apb_crc_pkg::DATA_W-1:0]  pwdata;
	logic [apb_crc_pkg::DATA_W-1:0]  prdata;
	logic                            pready;
	logic                            pslverr;

	// bridge side
	modport requester (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready,
		input  pslverr
	);

	// register block side
	modport completer (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready,
		output pslverr
	);

endinterface

// steering signals from the registers into the crc logic
interface crc_if;

	// single cycle pulses
	logic       clear;
	logic       byte_valid;
	logic [7:0] data_byte;
	// running crc
	logic [7:0] crc;

	modport steer (output clear, output byte_valid, output data_byte, input crc);

	modport engine (input clear, input byte_valid, input data_byte, output crc);

endinterface

//--- hdl/apb_crc_pkg.sv
package apb_crc_pkg;

	// apb bus widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// register offsets of the crc peripheral
	typedef enum logic [ADDR_W-1:0] {
		// bit 0 written as 1 clears the crc
		CRC_CTRL    = 8'h00,
		// bits 7:0 fed in as one byte
		CRC_DATA    = 8'h04,
		// read only, crc in bits 7:0
		CRC_RESULT  = 8'h08,
		// plain 32-bit read/write
		CRC_SCRATCH = 8'h0C
	} crc_reg_e;

	// crc value after reset or clear
	localparam logic [7:0] CRC_INIT = 8'h00;

	// upstream side of the four-phase req/ack crossing
	typedef enum logic [1:0] {
		HS_IDLE,
		// req raised, waiting for ack
		HS_REQ,
		// req dropped, waiting for ack to fall
		HS_WAIT_ACK_LOW
	} hs_state_e;

endpackage
